// File: source/mipsPkg.sv
// Shared widths, instruction encodings, ALU codes and the memory,
// control and retire structs
package mipsPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [7:0] memAddr_t;
	typedef logic [2:0] aluOp_t;
	typedef logic [1:0] branchKind_t;
	typedef logic [1:0] owner_t;

	localparam int MemWords = 256;
	localparam int NumRegs = 32;

	// ALU codes, 3'd4 left unused
	localparam aluOp_t AluAnd = 3'd0;
	localparam aluOp_t AluOr = 3'd1;
	localparam aluOp_t AluAdd = 3'd2;
	localparam aluOp_t AluSlt = 3'd3;
	localparam aluOp_t AluSll = 3'd5;
	localparam aluOp_t AluSub = 3'd6;
	localparam aluOp_t AluSltu = 3'd7;

	localparam logic [5:0] OpRType = 6'b000000;
	localparam logic [5:0] OpAddi = 6'b001000;
	localparam logic [5:0] OpLw = 6'b100011;
	localparam logic [5:0] OpSw = 6'b101011;
	localparam logic [5:0] OpBeq = 6'b000100;
	localparam logic [5:0] OpBne = 6'b000101;
	localparam logic [5:0] OpBgtz = 6'b000111;
	localparam logic [5:0] OpHalt = 6'b111111;

	localparam logic [5:0] FnAdd = 6'b100000;
	localparam logic [5:0] FnAddu = 6'b100001;
	localparam logic [5:0] FnSub = 6'b100010;
	localparam logic [5:0] FnSubu = 6'b100011;
	localparam logic [5:0] FnAnd = 6'b100100;
	localparam logic [5:0] FnOr = 6'b100101;
	localparam logic [5:0] FnSll = 6'b000000;
	localparam logic [5:0] FnSlt = 6'b101010;
	localparam logic [5:0] FnSltu = 6'b101011;

	localparam branchKind_t BrNone = 2'd0;
	localparam branchKind_t BrEq = 2'd1;
	localparam branchKind_t BrNe = 2'd2;
	localparam branchKind_t BrGtz = 2'd3;

	// Owner of the outstanding memory response
	localparam owner_t OwnerNone = 2'd0;
	localparam owner_t OwnerHost = 2'd1;
	localparam owner_t OwnerData = 2'd2;
	localparam owner_t OwnerFetch = 2'd3;

	typedef struct packed {
		logic write;
		memAddr_t addr;
		word_t wdata;
	} memReq_t;

	typedef struct packed {
		aluOp_t aluOp;
		logic useImm;
		logic signExt;
		logic regWrite;
		logic destIsRd;
		logic memRead;
		logic memWrite;
		branchKind_t branchKind;
		logic halt;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		logic regWrite;
		regAddr_t dest;
		word_t value;
	} retire_t;

endpackage

// File: source/instrDecoder.sv
// Instruction decoder, opcode and function code to control struct
`timescale 1ns/1ps
module instrDecoder (
	input  mipsPkg::word_t instr,
	output mipsPkg::ctrl_t ctrl
);
	import mipsPkg::*;

	logic [5:0] opcode;
	logic [5:0] funct;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];

	always_comb begin
		// Default is a no-op
		ctrl = '0;
		ctrl.aluOp = AluAdd;
		ctrl.branchKind = BrNone;
		case (opcode)
			OpRType: begin
				ctrl.regWrite = 1'b1;
				ctrl.destIsRd = 1'b1;
				case (funct)
					FnAdd, FnAddu: ctrl.aluOp = AluAdd;
					FnSub, FnSubu: ctrl.aluOp = AluSub;
					FnAnd: ctrl.aluOp = AluAnd;
					FnOr: ctrl.aluOp = AluOr;
					FnSll: ctrl.aluOp = AluSll;
					FnSlt: ctrl.aluOp = AluSlt;
					FnSltu: ctrl.aluOp = AluSltu;
					default: ctrl.regWrite = 1'b0;
				endcase
			end
			OpAddi: begin
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			OpLw: begin
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
			end
			OpSw: begin
				ctrl.useImm = 1'b1;
				ctrl.signExt = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			// Branches compare rs against rt
			OpBeq: ctrl.branchKind = BrEq;
			OpBne: ctrl.branchKind = BrNe;
			OpBgtz: ctrl.branchKind = BrGtz;
			OpHalt: ctrl.halt = 1'b1;
			default: ;
		endcase
	end

endmodule

// File: source/aluUnit.sv
// ALU with add, sub, logic, shift and compares, plus branch decision
`timescale 1ns/1ps
module aluUnit (
	input  mipsPkg::aluOp_t aluOp,
	input  mipsPkg::word_t a,
	input  mipsPkg::word_t b,
	input  logic [4:0] shamt,
	input  mipsPkg::branchKind_t branchKind,
	output mipsPkg::word_t result,
	output logic branchTaken
);
	import mipsPkg::*;

	always_comb begin
		case (aluOp)
			AluAnd: result = a & b;
			AluOr: result = a | b;
			AluAdd: result = a + b;
			AluSub: result = a - b;
			// sll shifts rt, which arrives on b
			AluSll: result = b << shamt;
			AluSlt: result = {31'b0, $signed(a) < $signed(b)};
			AluSltu: result = {31'b0, a < b};
			default: result = a + b;
		endcase
	end

	always_comb begin
		case (branchKind)
			BrEq: branchTaken = (a == b);
			BrNe: branchTaken = (a != b);
			// Strictly positive, signed
			BrGtz: branchTaken = !a[31] && (a != '0);
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// File: source/registerFile.sv
// 32-entry register file, two reads and one write, r0 reads zero
`timescale 1ns/1ps
module registerFile (
	input  logic clk,
	input  logic reset,
	input  mipsPkg::regAddr_t rs,
	input  mipsPkg::regAddr_t rt,
	input  logic writeEnable,
	input  mipsPkg::regAddr_t writeAddr,
	input  mipsPkg::word_t writeData,
	output mipsPkg::word_t rsData,
	output mipsPkg::word_t rtData
);
	import mipsPkg::*;

	word_t regs [NumRegs];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

// File: source/fetchUnit.sv
// Prefetching fetch unit with pc, one-entry buffer and redirect flush
`timescale 1ns/1ps
module fetchUnit (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic reqReady,
	input  logic rspValid,
	input  mipsPkg::word_t rdata,
	input  logic instrReady,
	input  logic redirectValid,
	input  mipsPkg::word_t redirectPc,
	output logic reqValid,
	output mipsPkg::memReq_t req,
	output logic instrValid,
	output mipsPkg::word_t instr,
	output mipsPkg::word_t instrPc
);
	import mipsPkg::*;

	word_t pc;
	word_t pendingPc;
	logic pending;
	logic stale;
	logic bufValid;
	logic accept;

	// One fetch in flight, and only into an empty buffer
	assign reqValid = run && !bufValid && !pending;
	assign req = '{write: 1'b0, addr: pc[9:2], wdata: '0};
	assign accept = reqValid && reqReady;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			pending <= 1'b0;
			stale <= 1'b0;
			bufValid <= 1'b0;
		end else begin
			if (accept) begin
				pending <= 1'b1;
			end else if (rspValid) begin
				pending <= 1'b0;
			end
			if (redirectValid) begin
				pc <= redirectPc;
				bufValid <= 1'b0;
				// Response still on its way belongs to the wrong path
				stale <= (pending && !rspValid) || accept;
			end else begin
				if (accept) begin
					pc <= pc + 32'd4;
				end
				if (rspValid) begin
					stale <= 1'b0;
					bufValid <= !stale;
				end else if (bufValid && instrReady) begin
					bufValid <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pendingPc <= pc;
		end
		if (rspValid) begin
			instr <= rdata;
			instrPc <= pendingPc;
		end
	end

	assign instrValid = bufValid;

endmodule

// File: source/executeCore.sv
// Execute FSM with memory access and retire; holds decoder, ALU and
// register file
`timescale 1ns/1ps
module executeCore (
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  mipsPkg::word_t instr,
	input  mipsPkg::word_t instrPc,
	input  logic reqReady,
	input  logic rspValid,
	input  mipsPkg::word_t rdata,
	output logic instrReady,
	output logic reqValid,
	output mipsPkg::memReq_t req,
	output logic redirectValid,
	output mipsPkg::word_t redirectPc,
	output logic retireValid,
	output mipsPkg::retire_t retire,
	output logic halted
);
	import mipsPkg::*;

	typedef enum logic [1:0] {
		Execute,
		MemRequest,
		MemWait,
		Halted
	} state_t;

	state_t state;
	ctrl_t ctrl;
	regAddr_t rtAddr;
	regAddr_t destAddr;
	word_t rsData;
	word_t rtData;
	word_t imm;
	word_t aluB;
	word_t aluResult;
	logic branchTaken;
	logic accept;
	logic isMemOp;
	memReq_t memReqReg;
	word_t memPc;
	regAddr_t memDest;
	logic memIsLoad;

	instrDecoder instrDecoder_i (
		.instr(instr),
		.ctrl (ctrl)
	);

	registerFile registerFile_i (
		.clk        (clk),
		.reset      (reset),
		.rs         (instr[25:21]),
		.rt         (rtAddr),
		.writeEnable(retireValid && retire.regWrite),
		.writeAddr  (retire.dest),
		.writeData  (retire.value),
		.rsData     (rsData),
		.rtData     (rtData)
	);

	assign rtAddr = instr[20:16];
	assign destAddr = ctrl.destIsRd ? instr[15:11] : rtAddr;
	assign imm = ctrl.signExt ? {{16{instr[15]}}, instr[15:0]} : {16'b0, instr[15:0]};
	assign aluB = ctrl.useImm ? imm : rtData;

	// Also forms load and store addresses as base plus offset
	aluUnit aluUnit_i (
		.aluOp      (ctrl.aluOp),
		.a          (rsData),
		.b          (aluB),
		.shamt      (instr[10:6]),
		.branchKind (ctrl.branchKind),
		.result     (aluResult),
		.branchTaken(branchTaken)
	);

	assign instrReady = (state == Execute);
	assign accept = instrReady && instrValid;
	assign isMemOp = ctrl.memRead || ctrl.memWrite;

	// Signed word offset relative to pc+4
	assign redirectValid = accept && branchTaken;
	assign redirectPc = instrPc + 32'd4 + {{14{instr[15]}}, instr[15:0], 2'b00};

	assign reqValid = (state == MemRequest);
	assign req = memReqReg;
	assign halted = (state == Halted);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= Execute;
		end else begin
			case (state)
				Execute: begin
					if (accept && ctrl.halt) begin
						state <= Halted;
					end else if (accept && isMemOp) begin
						state <= MemRequest;
					end
				end
				MemRequest: if (reqReady) state <= MemWait;
				MemWait: if (rspValid) state <= Execute;
				default: state <= Halted;
			endcase
		end
	end

	// Load/store held until its response
	always_ff @(posedge clk) begin
		if (accept && isMemOp) begin
			memReqReg <= '{write: ctrl.memWrite, addr: aluResult[9:2], wdata: rtData};
			memPc <= instrPc;
			memDest <= rtAddr;
			memIsLoad <= ctrl.memRead;
		end
	end

	// dest and value read as zero when nothing is written
	always_comb begin
		retireValid = 1'b0;
		retire = '0;
		if (accept && !isMemOp) begin
			retireValid = 1'b1;
			retire.pc = instrPc;
			retire.regWrite = ctrl.regWrite;
			if (ctrl.regWrite) begin
				retire.dest = destAddr;
				retire.value = aluResult;
			end
		end else if (state == MemWait && rspValid) begin
			retireValid = 1'b1;
			retire.pc = memPc;
			retire.regWrite = memIsLoad;
			if (memIsLoad) begin
				retire.dest = memDest;
				retire.value = rdata;
			end
		end
	end

endmodule

// File: source/memArbiter.sv
// Fixed-priority arbiter for host, core data and fetch with response routing
`timescale 1ns/1ps
module memArbiter (
	input  logic clk,
	input  logic reset,
	input  logic hostValid,
	input  mipsPkg::memReq_t hostReq,
	output logic hostReady,
	output logic hostRspValid,
	output mipsPkg::word_t hostRdata,
	input  logic dataValid,
	input  mipsPkg::memReq_t dataReq,
	output logic dataReady,
	output logic dataRspValid,
	output mipsPkg::word_t dataRdata,
	input  logic fetchValid,
	input  mipsPkg::memReq_t fetchReq,
	output logic fetchReady,
	output logic fetchRspValid,
	output mipsPkg::word_t fetchRdata,
	output logic memValid,
	output mipsPkg::memReq_t memReq,
	input  logic memRspValid,
	input  mipsPkg::word_t memRdata
);
	import mipsPkg::*;

	owner_t grant;
	owner_t owner;

	// Host first, then core data, then fetch
	always_comb begin
		if (hostValid) begin
			grant = OwnerHost;
			memReq = hostReq;
		end else if (dataValid) begin
			grant = OwnerData;
			memReq = dataReq;
		end else begin
			grant = fetchValid ? OwnerFetch : OwnerNone;
			memReq = fetchReq;
		end
	end

	assign memValid = (grant != OwnerNone);
	assign hostReady = (grant == OwnerHost);
	assign dataReady = (grant == OwnerData);
	assign fetchReady = (grant == OwnerFetch);

	// Response comes back next cycle, so the owner is just the last grant
	always_ff @(posedge clk) begin
		if (reset) begin
			owner <= OwnerNone;
		end else begin
			owner <= grant;
		end
	end

	assign hostRspValid = memRspValid && (owner == OwnerHost);
	assign dataRspValid = memRspValid && (owner == OwnerData);
	assign fetchRspValid = memRspValid && (owner == OwnerFetch);
	assign hostRdata = memRdata;
	assign dataRdata = memRdata;
	assign fetchRdata = memRdata;

endmodule

// File: source/unifiedMemory.sv
// Single-port word memory, one-cycle response
`timescale 1ns/1ps
module unifiedMemory (
	input  logic clk,
	input  logic valid,
	input  mipsPkg::memReq_t req,
	output logic rspValid,
	output mipsPkg::word_t rdata
);
	import mipsPkg::*;

	word_t mem [MemWords];

	always_ff @(posedge clk) begin
		if (valid) begin
			if (req.write) begin
				mem[req.addr] <= req.wdata;
			end
			// read-before-write, a store returns the old word
			rdata <= mem[req.addr];
		end
	end

	// Writes answer too, as their acknowledgement
	always_ff @(posedge clk) begin
		rspValid <= valid;
	end

endmodule

// File: source/mipsSubsystem.sv
// Processor subsystem top: fetch, core, host port, arbiter and memory
`timescale 1ns/1ps
module mipsSubsystem (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic hostReqValid,
	input  mipsPkg::memReq_t hostReq,
	output logic hostReqReady,
	output logic hostRspValid,
	output mipsPkg::word_t hostRdata,
	output logic retireValid,
	output mipsPkg::retire_t retire,
	output logic halted
);
	import mipsPkg::*;

	logic fetchReqValid;
	logic fetchReqReady;
	logic fetchRspValid;
	memReq_t fetchReq;
	word_t fetchRdata;
	logic dataReqValid;
	logic dataReqReady;
	logic dataRspValid;
	memReq_t dataReq;
	word_t dataRdata;
	logic memValid;
	logic memRspValid;
	memReq_t memReq;
	word_t memRdata;
	logic instrValid;
	logic instrReady;
	word_t instr;
	word_t instrPc;
	logic redirectValid;
	word_t redirectPc;

	fetchUnit fetchUnit_i (
		.clk          (clk),
		.reset        (reset),
		.run          (run),
		.reqReady     (fetchReqReady),
		.rspValid     (fetchRspValid),
		.rdata        (fetchRdata),
		.instrReady   (instrReady),
		.redirectValid(redirectValid),
		.redirectPc   (redirectPc),
		.reqValid     (fetchReqValid),
		.req          (fetchReq),
		.instrValid   (instrValid),
		.instr        (instr),
		.instrPc      (instrPc)
	);

	executeCore executeCore_i (
		.clk          (clk),
		.reset        (reset),
		.instrValid   (instrValid),
		.instr        (instr),
		.instrPc      (instrPc),
		.reqReady     (dataReqReady),
		.rspValid     (dataRspValid),
		.rdata        (dataRdata),
		.instrReady   (instrReady),
		.reqValid     (dataReqValid),
		.req          (dataReq),
		.redirectValid(redirectValid),
		.redirectPc   (redirectPc),
		.retireValid  (retireValid),
		.retire       (retire),
		.halted       (halted)
	);

	memArbiter memArbiter_i (
		.clk          (clk),
		.reset        (reset),
		.hostValid    (hostReqValid),
		.hostReq      (hostReq),
		.hostReady    (hostReqReady),
		.hostRspValid (hostRspValid),
		.hostRdata    (hostRdata),
		.dataValid    (dataReqValid),
		.dataReq      (dataReq),
		.dataReady    (dataReqReady),
		.dataRspValid (dataRspValid),
		.dataRdata    (dataRdata),
		.fetchValid   (fetchReqValid),
		.fetchReq     (fetchReq),
		.fetchReady   (fetchReqReady),
		.fetchRspValid(fetchRspValid),
		.fetchRdata   (fetchRdata),
		.memValid     (memValid),
		.memReq       (memReq),
		.memRspValid  (memRspValid),
		.memRdata     (memRdata)
	);

	unifiedMemory unifiedMemory_i (
		.clk     (clk),
		.valid   (memValid),
		.req     (memReq),
		.rspValid(memRspValid),
		.rdata   (memRdata)
	);

endmodule

// File: dv/mipsSubsystem_sva.sv
// Assertions on arbiter grants, memory response timing and core halt
`timescale 1ns/1ps
module mipsSubsystem_sva (
	input logic clk,
	input logic reset,
	input logic hostReady,
	input logic dataReady,
	input logic fetchReady,
	input logic memValid,
	input logic memRspValid,
	input logic halted,
	input logic retireValid
);

	int assertErrors = 0;

	oneGrant: assert property (@(posedge clk) disable iff (reset)
		$onehot0({hostReady, dataReady, fetchReady}))
		else begin
			$error("more than one requester granted in one cycle");
			assertErrors++;
		end

	// Response exactly one cycle after each accepted request
	rspTiming: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (memRspValid == $past(memValid)))
		else begin
			$error("memory response not one cycle after its request");
			assertErrors++;
		end

	haltSticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> halted)
		else begin
			$error("halted dropped before reset");
			assertErrors++;
		end

	noRetireAfterHalt: assert property (@(posedge clk) disable iff (reset)
		halted |=> !retireValid)
		else begin
			$error("retire after the core halted");
			assertErrors++;
		end

endmodule

bind mipsSubsystem mipsSubsystem_sva mipsSubsystem_sva_i (
	.clk        (clk),
	.reset      (reset),
	.hostReady  (hostReqReady),
	.dataReady  (dataReqReady),
	.fetchReady (fetchReqReady),
	.memValid   (memValid),
	.memRspValid(memRspValid),
	.halted     (halted),
	.retireValid(retireValid)
);

// File: dv/mipsSubsystemTb.sv
// Testbench for the processor subsystem with random programs, an ISA
// reference model, and retire and memory checks
`timescale 1ns/1ps
module mipsSubsystemTb;
	import mipsPkg::*;

	localparam int DataBase = 128;
	localparam int ProgLen = 60;
	localparam int ProgRegion = 128;
	localparam int NumPrograms = 3;
	localparam int RunTimeout = 4000;
	localparam int HostTimeout = 100;
	localparam int HostReads = 16;
	localparam logic [5:0] OpUnknown = 6'b010001;

	logic clk;
	logic reset;
	logic run;
	logic hostReqValid;
	memReq_t hostReq;
	logic hostReqReady;
	logic hostRspValid;
	word_t hostRdata;
	logic retireValid;
	retire_t retire;
	logic halted;

	word_t lfsr;
	word_t image [MemWords];
	word_t modelMem [MemWords];
	retire_t expected [$];
	int lastStore;
	int retireErrors;
	int memErrors;
	int hostErrors;
	int statusErrors;
	int timeouts;

	mipsSubsystem mipsSubsystem_i (
		.clk         (clk),
		.reset       (reset),
		.run         (run),
		.hostReqValid(hostReqValid),
		.hostReq     (hostReq),
		.hostReqReady(hostReqReady),
		.hostRspValid(hostRspValid),
		.hostRdata   (hostRdata),
		.retireValid (retireValid),
		.retire      (retire),
		.halted      (halted)
	);

	always #50 clk = ~clk;

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic word_t randBits(input int n);
		word_t v;
		logic fb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Only r0 to r7, so instructions depend on each other often
	function automatic regAddr_t pickReg();
		word_t v;
		v = randBits(3);
		return v[4:0];
	endfunction

	function automatic word_t makeInstr(input int i);
		word_t kind;
		word_t sel;
		word_t off;
		word_t r;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [5:0] fn;
		kind = randBits(4);
		rs = pickReg();
		rt = pickReg();
		rd = pickReg();
		if (kind < 5) begin
			sel = randBits(4) % 9;
			case (sel)
				0: fn = FnAdd;
				1: fn = FnAddu;
				2: fn = FnSub;
				3: fn = FnSubu;
				4: fn = FnAnd;
				5: fn = FnOr;
				6: fn = FnSll;
				7: fn = FnSlt;
				default: fn = FnSltu;
			endcase
			off = (fn == FnSll) ? randBits(5) : '0;
			r = {OpRType, rs, rt, rd, off[4:0], fn};
		end else if (kind < 8) begin
			off = randBits(16);
			r = {OpAddi, rs, rt, off[15:0]};
		end else if (kind < 10) begin
			off = DataBase + randBits(7);
			// Often reread the last stored word
			if (lastStore >= 0 && randBits(1) == 1) begin
				off = lastStore;
			end
			off = off << 2;
			r = {OpLw, 5'd0, rt, off[15:0]};
		end else if (kind < 12) begin
			off = DataBase + randBits(7);
			lastStore = off;
			off = off << 2;
			r = {OpSw, 5'd0, rt, off[15:0]};
		end else if (kind < 15) begin
			// Forward only and at most up to the halt word
			off = randBits(3);
			if (i + 1 + off > ProgLen) begin
				off = ProgLen - 1 - i;
			end
			if (kind == 12) begin
				r = {OpBeq, rs, rt, off[15:0]};
			end else if (kind == 13) begin
				r = {OpBne, rs, rt, off[15:0]};
			end else begin
				r = {OpBgtz, rs, 5'd0, off[15:0]};
			end
		end else begin
			off = randBits(26);
			r = {OpUnknown, off[25:0]};
		end
		return r;
	endfunction

	task automatic buildImage();
		lastStore = -1;
		for (int i = 0; i < MemWords; i++) begin
			if (i < ProgLen) begin
				image[i] = makeInstr(i);
			end else if (i < ProgRegion) begin
				image[i] = {OpHalt, 26'd0};
			end else begin
				image[i] = randBits(32);
			end
		end
	endtask

	// ISA model filling the expected retire list and final memory
	task automatic runModel();
		word_t regs [NumRegs];
		word_t pc;
		word_t nextPc;
		word_t ins;
		word_t a;
		word_t b;
		word_t simm;
		word_t ea;
		retire_t r;
		bit done;
		int steps;
		expected.delete();
		for (int k = 0; k < NumRegs; k++) begin
			regs[k] = '0;
		end
		for (int k = 0; k < MemWords; k++) begin
			modelMem[k] = image[k];
		end
		pc = '0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			ins = modelMem[pc[9:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			ea = a + simm;
			r = '0;
			r.pc = pc;
			nextPc = pc + 4;
			case (ins[31:26])
				OpRType: begin
					r.regWrite = 1'b1;
					r.dest = ins[15:11];
					case (ins[5:0])
						FnAdd, FnAddu: r.value = a + b;
						FnSub, FnSubu: r.value = a - b;
						FnAnd: r.value = a & b;
						FnOr: r.value = a | b;
						FnSll: r.value = b << ins[10:6];
						FnSlt: r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FnSltu: r.value = (a < b) ? 32'd1 : 32'd0;
						default: r.regWrite = 1'b0;
					endcase
				end
				OpAddi: begin
					r.regWrite = 1'b1;
					r.dest = ins[20:16];
					r.value = ea;
				end
				OpLw: begin
					r.regWrite = 1'b1;
					r.dest = ins[20:16];
					r.value = modelMem[ea[9:2]];
				end
				OpSw: modelMem[ea[9:2]] = b;
				OpBeq: if (a == b) nextPc = pc + 4 + (simm << 2);
				OpBne: if (a != b) nextPc = pc + 4 + (simm << 2);
				OpBgtz: if ($signed(a) > 0) nextPc = pc + 4 + (simm << 2);
				OpHalt: done = 1'b1;
				default: ;
			endcase
			// r0 stays zero whatever the retire record shows
			if (r.regWrite && r.dest != '0) begin
				regs[r.dest] = r.value;
			end
			expected.push_back(r);
			pc = nextPc;
			steps++;
		end
	endtask

	task automatic applyReset();
		reset = 1'b1;
		run = 1'b0;
		hostReqValid = 1'b0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
	endtask

	// Entered just after a falling edge
	task automatic hostAccess(input logic write, input memAddr_t addr, input word_t wdata,
			output word_t rdata, output bit ok);
		int n;
		ok = 1'b0;
		rdata = '0;
		hostReq.write = write;
		hostReq.addr = addr;
		hostReq.wdata = wdata;
		hostReqValid = 1'b1;
		n = 0;
		#1;
		while (!hostReqReady && n < HostTimeout) begin
			@(negedge clk);
			#1;
			n++;
		end
		if (!hostReqReady) begin
			hostReqValid = 1'b0;
			timeouts++;
			$display("Timeout: host request to word %0d was never accepted", addr);
		end else begin
			// Transfer at the rising edge in between
			@(negedge clk);
			hostReqValid = 1'b0;
			n = 0;
			while (!hostRspValid && n < HostTimeout) begin
				@(negedge clk);
				n++;
			end
			if (hostRspValid) begin
				rdata = hostRdata;
				ok = 1'b1;
			end else begin
				timeouts++;
				$display("Timeout: no host response for word %0d", addr);
			end
		end
	endtask

	task automatic loadImage();
		word_t unused;
		bit ok;
		for (int i = 0; i < MemWords; i++) begin
			hostAccess(1'b1, memAddr_t'(i), image[i], unused, ok);
		end
	endtask

	task automatic checkRetires();
		int idx;
		int cycles;
		bit haltSeen;
		retire_t exp;
		idx = 0;
		cycles = 0;
		haltSeen = 1'b0;
		while (!haltSeen && cycles < RunTimeout) begin
			@(negedge clk);
			cycles++;
			assert (!halted) else begin
				statusErrors++;
				$display("** Error at %0t ns: halted high before the halt retired", $time);
			end
			if (retireValid) begin
				exp = expected[idx];
				assert (retire.pc == exp.pc && retire.regWrite == exp.regWrite &&
						(!exp.regWrite || (retire.dest == exp.dest && retire.value == exp.value)))
				else begin
					retireErrors++;
					$display("** Error at %0t ns: retire %0d expected pc %h w %b r%0d %h",
						$time, idx, exp.pc, exp.regWrite, exp.dest, exp.value);
					$display("   got pc %h w %b r%0d %h",
						retire.pc, retire.regWrite, retire.dest, retire.value);
				end
				haltSeen = (idx == expected.size() - 1);
				idx++;
			end
		end
		if (!haltSeen) begin
			timeouts++;
			$display("Timeout: halt never retired, %0d of %0d retires seen", idx, expected.size());
		end else begin
			@(negedge clk);
			assert (halted) else begin
				statusErrors++;
				$display("** Error at %0t ns: halted did not rise after the halt retire", $time);
			end
			repeat (50) begin
				@(negedge clk);
				assert (!retireValid && halted) else begin
					statusErrors++;
					$display("** Error at %0t ns: retire or halted change after halt", $time);
				end
			end
		end
	endtask

	// Host reads of the program region compete with the running core
	task automatic readWhileRunning();
		word_t gap;
		word_t addr;
		word_t data;
		bit ok;
		for (int n = 0; n < HostReads; n++) begin
			gap = randBits(2);
			repeat (gap) @(negedge clk);
			addr = randBits(7);
			hostAccess(1'b0, addr[7:0], '0, data, ok);
			if (ok) begin
				assert (data == image[addr[7:0]]) else begin
					hostErrors++;
					$display("** Error at %0t ns: program word %0d read %h, expected %h",
						$time, addr, data, image[addr[7:0]]);
				end
			end
		end
	endtask

	task automatic checkDataRegion();
		word_t data;
		bit ok;
		for (int i = DataBase; i < MemWords; i++) begin
			hostAccess(1'b0, memAddr_t'(i), '0, data, ok);
			if (ok) begin
				assert (data == modelMem[i]) else begin
					memErrors++;
					$display("** Error at %0t ns: data word %0d read %h, expected %h",
						$time, i, data, modelMem[i]);
				end
			end
		end
	endtask

	initial begin
		int total;
		int svaErrors;
		clk = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		hostReqValid = 1'b0;
		hostReq = '0;
		lfsr = 32'd93695;
		retireErrors = 0;
		memErrors = 0;
		hostErrors = 0;
		statusErrors = 0;
		timeouts = 0;
		for (int p = 0; p < NumPrograms; p++) begin
			applyReset();
			buildImage();
			loadImage();
			runModel();
			run = 1'b1;
			fork
				checkRetires();
				readWhileRunning();
			join
			checkDataRegion();
			run = 1'b0;
		end
		svaErrors = mipsSubsystem_i.mipsSubsystem_sva_i.assertErrors;
		total = retireErrors + memErrors + hostErrors + statusErrors + timeouts + svaErrors;
		$display("Errors: retire %0d, memory %0d, host %0d, status %0d, timeouts %0d, sva %0d",
			retireErrors, memErrors, hostErrors, statusErrors, timeouts, svaErrors);
		if (total == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: list.f
source/mipsPkg.sv
source/instrDecoder.sv
source/aluUnit.sv
source/registerFile.sv
source/fetchUnit.sv
source/executeCore.sv
source/memArbiter.sv
source/unifiedMemory.sv
source/mipsSubsystem.sv
dv/mipsSubsystem_sva.sv
dv/mipsSubsystemTb.sv

// File: Bender.yml
package:
  name: mips_subsystem

sources:
  - source/mipsPkg.sv
  - source/instrDecoder.sv
  - source/aluUnit.sv
  - source/registerFile.sv
  - source/fetchUnit.sv
  - source/executeCore.sv
  - source/memArbiter.sv
  - source/unifiedMemory.sv
  - source/mipsSubsystem.sv
  - target: test
    files:
      - dv/mipsSubsystem_sva.sv
      - dv/mipsSubsystemTb.sv
